//--- apu_cluster_cfg.svh
// Shared arithmetic cluster configuration
// Core count, datapath widths and unit latencies

`ifndef APU_CLUSTER_CFG_SVH
`define APU_CLUSTER_CFG_SVH

// Cores sharing the execution units
`define APU_NB_CORES 2

// Operand and result width
`define APU_DATA_W 32

// Tag a core attaches to each request
`define APU_TAG_W 4

// Multiplier pipeline depth, at least 1
`define APU_MULT_STAGES 2

// One divider iteration per quotient bit
`define APU_DIV_CYCLES `APU_DATA_W

`endif

//--- apu_pkg.sv
// Shared arithmetic cluster types
// Operand words, tags, core index and the unit and opcode encodings

`include "apu_cluster_cfg.svh"

package apu_pkg;

   // Core index width, kept at one bit for a single core
   localparam int CORE_W = (`APU_NB_CORES > 1) ? $clog2(`APU_NB_CORES) : 1;

   typedef logic [`APU_DATA_W-1:0] word_t;
   typedef logic [`APU_TAG_W-1:0]  cpu_tag_t;
   typedef logic [CORE_W-1:0]      core_idx_t;

   // Unit type a request is steered to
   typedef enum logic [0:0] {
      APU_MULT = 1'b0,
      APU_DIV  = 1'b1
   } apu_type_e;

   // Opcodes, multiplier first, then divider
   typedef enum logic [2:0] {
      OP_MUL  = 3'd0,
      OP_MULH = 3'd1,
      OP_MAC  = 3'd2,
      OP_DIVU = 3'd3,
      OP_REMU = 3'd4
   } apu_op_e;

endpackage

//--- apu_core_port.sv
// Per-core port of the arithmetic cluster
// Steers a request to one unit type and merges the returning results

`timescale 1ns/100ps

module apu_core_port (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                req_i,
   input  apu_pkg::apu_type_e  type_i,
   input  apu_pkg::apu_op_e    op_i,
   input  apu_pkg::word_t      opa_i,
   input  apu_pkg::word_t      opb_i,
   input  apu_pkg::word_t      opc_i,
   input  apu_pkg::cpu_tag_t   tag_i,
   input  logic                ready_i,
   input  logic                mult_ack_i,
   input  logic                div_ack_i,
   input  logic                mult_valid_i,
   input  logic                div_valid_i,
   input  apu_pkg::word_t      mult_result_i,
   input  apu_pkg::word_t      div_result_i,
   input  apu_pkg::cpu_tag_t   mult_tag_i,
   input  apu_pkg::cpu_tag_t   div_tag_i,
   output logic                mult_req_o,
   output logic                div_req_o,
   output apu_pkg::apu_op_e    arb_op_o,
   output apu_pkg::word_t      arb_opa_o,
   output apu_pkg::word_t      arb_opb_o,
   output apu_pkg::word_t      arb_opc_o,
   output apu_pkg::cpu_tag_t   arb_tag_o,
   output logic                ack_o,
   output logic                valid_o,
   output apu_pkg::word_t      result_o,
   output apu_pkg::cpu_tag_t   tag_o,
   output logic                mult_ready_o,
   output logic                div_ready_o
);
   import apu_pkg::*;

   logic pick_div;
   logic hold_div_q;

   //////////////////////////////
   // Request side
   //////////////////////////////

   assign mult_req_o = req_i && (type_i == APU_MULT);
   assign div_req_o  = req_i && (type_i == APU_DIV);

   // Payload bus stays quiet without a request
   assign arb_op_o  = req_i ? op_i : OP_MUL;
   assign arb_opa_o = req_i ? opa_i : '0;
   assign arb_opb_o = req_i ? opb_i : '0;
   assign arb_opc_o = req_i ? opc_i : '0;
   assign arb_tag_o = req_i ? tag_i : '0;

   assign ack_o = mult_ack_i | div_ack_i;

   //////////////////////////////
   // Result merge
   //////////////////////////////

   // Multiplier first, unless a divider result is already on display
   assign pick_div = div_valid_i && (!mult_valid_i || hold_div_q);

   assign valid_o      = mult_valid_i | div_valid_i;
   assign result_o     = pick_div ? div_result_i : mult_result_i;
   assign tag_o        = pick_div ? div_tag_i : mult_tag_i;
   assign mult_ready_o = ready_i && !pick_div;
   assign div_ready_o  = ready_i && pick_div;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         hold_div_q <= 1'b0;
      end else begin
         hold_div_q <= pick_div && !ready_i;
      end
   end

   // Both arbiters must never take the same request
   a_one_ack : assert property (@(posedge clk_i) disable iff (rst_i)
      !(mult_ack_i && div_ack_i))
      else $error("core port acked by both unit types");

endmodule

//--- apu_arbiter.sv
// Round-robin arbiter for one shared unit type
// Grants one core per cycle and routes unit results back by core index

`timescale 1ns/100ps

`include "apu_cluster_cfg.svh"

module apu_arbiter #(
   parameter int NCPUS = `APU_NB_CORES
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [NCPUS-1:0]    req_i,
   input  apu_pkg::apu_op_e    op_i     [NCPUS],
   input  apu_pkg::word_t      opa_i    [NCPUS],
   input  apu_pkg::word_t      opb_i    [NCPUS],
   input  apu_pkg::word_t      opc_i    [NCPUS],
   input  apu_pkg::cpu_tag_t   tag_i    [NCPUS],
   input  logic [NCPUS-1:0]    ready_i,
   input  logic                unit_ready_i,
   input  logic                unit_valid_i,
   input  apu_pkg::word_t      unit_result_i,
   input  apu_pkg::cpu_tag_t   unit_tag_i,
   input  apu_pkg::core_idx_t  unit_core_i,
   output logic [NCPUS-1:0]    ack_o,
   output logic [NCPUS-1:0]    valid_o,
   output apu_pkg::word_t      result_o [NCPUS],
   output apu_pkg::cpu_tag_t   tag_o    [NCPUS],
   output logic                unit_en_o,
   output apu_pkg::apu_op_e    unit_op_o,
   output apu_pkg::word_t      unit_opa_o,
   output apu_pkg::word_t      unit_opb_o,
   output apu_pkg::word_t      unit_opc_o,
   output apu_pkg::cpu_tag_t   unit_tag_o,
   output apu_pkg::core_idx_t  unit_core_o,
   output logic                unit_ready_o
);
   import apu_pkg::*;

   core_idx_t rr_q;
   core_idx_t grant_idx;
   core_idx_t next_ptr;
   logic      any_req;

   //////////////////////////////
   // Grant
   //////////////////////////////

   // First pending core at or after the pointer
   always_comb begin
      int idx;
      any_req   = 1'b0;
      grant_idx = rr_q;
      for (int k = 0; k < NCPUS; k++) begin
         idx = (int'(rr_q) + k) % NCPUS;
         if (!any_req && req_i[idx]) begin
            any_req   = 1'b1;
            grant_idx = core_idx_t'(idx);
         end
      end
   end

   assign unit_en_o = any_req && unit_ready_i;
   assign next_ptr  = core_idx_t'((int'(grant_idx) + 1) % NCPUS);

   always_comb begin
      ack_o = '0;
      if (unit_en_o) begin
         ack_o[grant_idx] = 1'b1;
      end
   end

   assign unit_op_o   = op_i[grant_idx];
   assign unit_opa_o  = opa_i[grant_idx];
   assign unit_opb_o  = opb_i[grant_idx];
   assign unit_opc_o  = opc_i[grant_idx];
   assign unit_tag_o  = tag_i[grant_idx];
   assign unit_core_o = grant_idx;

   // Pointer moves past the core just served
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rr_q <= '0;
      end else if (unit_en_o) begin
         rr_q <= next_ptr;
      end
   end

   //////////////////////////////
   // Result routing
   //////////////////////////////

   for (genvar i = 0; i < NCPUS; i++) begin : g_route
      assign valid_o[i]  = unit_valid_i && (unit_core_i == core_idx_t'(i));
      assign result_o[i] = unit_result_i;
      assign tag_o[i]    = unit_tag_i;
   end

   assign unit_ready_o = ready_i[unit_core_i];

   // Single grant to a requesting core
   a_ack_onehot : assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(ack_o) && ((ack_o & ~req_i) == '0))
      else $error("arbiter acked more than one core or a core without a request");

endmodule

//--- apu_int_mult.sv
// Pipelined 32-bit integer multiplier
// Low product, unsigned high product and multiply-accumulate

`timescale 1ns/100ps

`include "apu_cluster_cfg.svh"

module apu_int_mult (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                en_i,
   input  apu_pkg::apu_op_e    op_i,
   input  apu_pkg::word_t      opa_i,
   input  apu_pkg::word_t      opb_i,
   input  apu_pkg::word_t      opc_i,
   input  apu_pkg::cpu_tag_t   tag_i,
   input  apu_pkg::core_idx_t  core_i,
   input  logic                ack_i,
   output logic                ready_o,
   output logic                valid_o,
   output apu_pkg::word_t      result_o,
   output apu_pkg::cpu_tag_t   tag_o,
   output apu_pkg::core_idx_t  core_o
);
   import apu_pkg::*;

   localparam int S = `APU_MULT_STAGES;
   localparam int W = `APU_DATA_W;

   logic [S-1:0]     vld_q;
   logic [2*W-1:0]   prod_q [S];
   apu_op_e          op_q   [S];
   word_t            opc_q  [S];
   cpu_tag_t         tag_q  [S];
   core_idx_t        core_q [S];
   logic             stall;

   // Whole pipe freezes behind an unaccepted result
   assign stall   = vld_q[S-1] && !ack_i;
   assign ready_o = !stall;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vld_q <= '0;
      end else if (!stall) begin
         vld_q[0] <= en_i;
         for (int k = 1; k < S; k++) begin
            vld_q[k] <= vld_q[k-1];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!stall) begin
         prod_q[0] <= {{W{1'b0}}, opa_i} * {{W{1'b0}}, opb_i};
         op_q[0]   <= op_i;
         opc_q[0]  <= opc_i;
         tag_q[0]  <= tag_i;
         core_q[0] <= core_i;
         for (int k = 1; k < S; k++) begin
            prod_q[k] <= prod_q[k-1];
            op_q[k]   <= op_q[k-1];
            opc_q[k]  <= opc_q[k-1];
            tag_q[k]  <= tag_q[k-1];
            core_q[k] <= core_q[k-1];
         end
      end
   end

   // Final select
   always_comb begin
      case (op_q[S-1])
         OP_MULH: result_o = prod_q[S-1][2*W-1:W];
         OP_MAC:  result_o = prod_q[S-1][W-1:0] + opc_q[S-1];
         default: result_o = prod_q[S-1][W-1:0];
      endcase
   end

   assign valid_o = vld_q[S-1];
   assign tag_o   = tag_q[S-1];
   assign core_o  = core_q[S-1];

   a_mult_op : assert property (@(posedge clk_i) disable iff (rst_i)
      en_i |-> (op_i inside {OP_MUL, OP_MULH, OP_MAC}))
      else $error("multiplier issued a non-multiply opcode");

endmodule

//--- apu_int_div.sv
// Iterative 32-bit unsigned divider
// Restoring shift-subtract, one quotient bit per cycle

`timescale 1ns/100ps

`include "apu_cluster_cfg.svh"

module apu_int_div (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                en_i,
   input  apu_pkg::apu_op_e    op_i,
   input  apu_pkg::word_t      opa_i,
   input  apu_pkg::word_t      opb_i,
   input  apu_pkg::cpu_tag_t   tag_i,
   input  apu_pkg::core_idx_t  core_i,
   input  logic                ack_i,
   output logic                ready_o,
   output logic                valid_o,
   output apu_pkg::word_t      result_o,
   output apu_pkg::cpu_tag_t   tag_o,
   output apu_pkg::core_idx_t  core_o
);
   import apu_pkg::*;

   localparam int W     = `APU_DATA_W;
   localparam int CNT_W = $clog2(`APU_DIV_CYCLES);

   typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

   state_e           state_q;
   logic [CNT_W-1:0] cnt_q;
   word_t            quo_q;
   word_t            rem_q;
   word_t            dvs_q;
   apu_op_e          op_q;
   cpu_tag_t         tag_q;
   core_idx_t        core_q;
   logic [W:0]       rem_sh;
   logic [W:0]       diff;

   // Trial subtract of the divisor from the shifted partial remainder
   assign rem_sh = {rem_q, quo_q[W-1]};
   assign diff   = rem_sh - {1'b0, dvs_q};

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            IDLE: if (en_i) begin
               state_q <= RUN;
               cnt_q   <= CNT_W'(`APU_DIV_CYCLES - 1);
            end
            RUN: begin
               cnt_q <= cnt_q - 1'b1;
               if (cnt_q == '0) begin
                  state_q <= DONE;
               end
            end
            default: if (ack_i) begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && en_i) begin
         quo_q  <= opa_i;
         rem_q  <= '0;
         dvs_q  <= opb_i;
         op_q   <= op_i;
         tag_q  <= tag_i;
         core_q <= core_i;
      end else if (state_q == RUN) begin
         // Zero divisor always fits, giving all ones and the dividend back
         if (!diff[W]) begin
            rem_q <= diff[W-1:0];
            quo_q <= {quo_q[W-2:0], 1'b1};
         end else begin
            rem_q <= rem_sh[W-1:0];
            quo_q <= {quo_q[W-2:0], 1'b0};
         end
      end
   end

   assign ready_o  = (state_q == IDLE);
   assign valid_o  = (state_q == DONE);
   assign result_o = (op_q == OP_REMU) ? rem_q : quo_q;
   assign tag_o    = tag_q;
   assign core_o   = core_q;

   a_en_idle : assert property (@(posedge clk_i) disable iff (rst_i)
      en_i |-> (state_q == IDLE))
      else $error("divider enabled while busy");

endmodule

//--- apu_cluster.sv
// Shared arithmetic cluster top level
// Core ports, one arbiter per unit type, integer multiplier and divider

`timescale 1ns/100ps

`include "apu_cluster_cfg.svh"

module apu_cluster (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic [`APU_NB_CORES-1:0] req_i,
   input  apu_pkg::apu_type_e       type_i   [`APU_NB_CORES],
   input  apu_pkg::apu_op_e         op_i     [`APU_NB_CORES],
   input  apu_pkg::word_t           opa_i    [`APU_NB_CORES],
   input  apu_pkg::word_t           opb_i    [`APU_NB_CORES],
   input  apu_pkg::word_t           opc_i    [`APU_NB_CORES],
   input  apu_pkg::cpu_tag_t        tag_i    [`APU_NB_CORES],
   input  logic [`APU_NB_CORES-1:0] ready_i,
   output logic [`APU_NB_CORES-1:0] ack_o,
   output logic [`APU_NB_CORES-1:0] valid_o,
   output apu_pkg::word_t           result_o [`APU_NB_CORES],
   output apu_pkg::cpu_tag_t        tag_o    [`APU_NB_CORES]
);
   import apu_pkg::*;

   localparam int NCORES = `APU_NB_CORES;

   // Core port to arbiter
   logic [NCORES-1:0] mult_req, div_req, mult_ack, div_ack;
   logic [NCORES-1:0] mult_valid, div_valid, mult_ready, div_ready;
   apu_op_e           arb_op      [NCORES];
   word_t             arb_opa     [NCORES];
   word_t             arb_opb     [NCORES];
   word_t             arb_opc     [NCORES];
   cpu_tag_t          arb_tag     [NCORES];
   word_t             mult_result [NCORES];
   word_t             div_result  [NCORES];
   cpu_tag_t          mult_tag    [NCORES];
   cpu_tag_t          div_tag     [NCORES];

   // Arbiter to unit
   logic      mu_en, mu_rdy, mu_vld, mu_ack;
   apu_op_e   mu_op;
   word_t     mu_opa, mu_opb, mu_opc, mu_res;
   cpu_tag_t  mu_tag, mu_rtag;
   core_idx_t mu_core, mu_rcore;
   logic      dv_en, dv_rdy, dv_vld, dv_ack;
   apu_op_e   dv_op;
   word_t     dv_opa, dv_opb, dv_res;
   cpu_tag_t  dv_tag, dv_rtag;
   core_idx_t dv_core, dv_rcore;

   for (genvar i = 0; i < NCORES; i++) begin : g_core
      apu_core_port u_core_port (
         .clk_i, .rst_i,
         .req_i(req_i[i]), .type_i(type_i[i]), .op_i(op_i[i]),
         .opa_i(opa_i[i]), .opb_i(opb_i[i]), .opc_i(opc_i[i]), .tag_i(tag_i[i]),
         .ready_i(ready_i[i]),
         .mult_ack_i(mult_ack[i]), .div_ack_i(div_ack[i]),
         .mult_valid_i(mult_valid[i]), .div_valid_i(div_valid[i]),
         .mult_result_i(mult_result[i]), .div_result_i(div_result[i]),
         .mult_tag_i(mult_tag[i]), .div_tag_i(div_tag[i]),
         .mult_req_o(mult_req[i]), .div_req_o(div_req[i]),
         .arb_op_o(arb_op[i]), .arb_opa_o(arb_opa[i]), .arb_opb_o(arb_opb[i]),
         .arb_opc_o(arb_opc[i]), .arb_tag_o(arb_tag[i]),
         .ack_o(ack_o[i]), .valid_o(valid_o[i]),
         .result_o(result_o[i]), .tag_o(tag_o[i]),
         .mult_ready_o(mult_ready[i]), .div_ready_o(div_ready[i])
      );
   end

   //////////////////////////////
   // Multiplier
   //////////////////////////////

   apu_arbiter #(.NCPUS(NCORES)) u_arb_mult (
      .clk_i, .rst_i,
      .req_i(mult_req), .op_i(arb_op), .opa_i(arb_opa), .opb_i(arb_opb),
      .opc_i(arb_opc), .tag_i(arb_tag), .ready_i(mult_ready),
      .unit_ready_i(mu_rdy), .unit_valid_i(mu_vld), .unit_result_i(mu_res),
      .unit_tag_i(mu_rtag), .unit_core_i(mu_rcore),
      .ack_o(mult_ack), .valid_o(mult_valid), .result_o(mult_result), .tag_o(mult_tag),
      .unit_en_o(mu_en), .unit_op_o(mu_op), .unit_opa_o(mu_opa), .unit_opb_o(mu_opb),
      .unit_opc_o(mu_opc), .unit_tag_o(mu_tag), .unit_core_o(mu_core),
      .unit_ready_o(mu_ack)
   );

   apu_int_mult u_int_mult (
      .clk_i, .rst_i,
      .en_i(mu_en), .op_i(mu_op), .opa_i(mu_opa), .opb_i(mu_opb), .opc_i(mu_opc),
      .tag_i(mu_tag), .core_i(mu_core), .ack_i(mu_ack),
      .ready_o(mu_rdy), .valid_o(mu_vld), .result_o(mu_res),
      .tag_o(mu_rtag), .core_o(mu_rcore)
   );

   //////////////////////////////
   // Divider
   //////////////////////////////

   // Third operand has no use in the divider
   apu_arbiter #(.NCPUS(NCORES)) u_arb_div (
      .clk_i, .rst_i,
      .req_i(div_req), .op_i(arb_op), .opa_i(arb_opa), .opb_i(arb_opb),
      .opc_i(arb_opc), .tag_i(arb_tag), .ready_i(div_ready),
      .unit_ready_i(dv_rdy), .unit_valid_i(dv_vld), .unit_result_i(dv_res),
      .unit_tag_i(dv_rtag), .unit_core_i(dv_rcore),
      .ack_o(div_ack), .valid_o(div_valid), .result_o(div_result), .tag_o(div_tag),
      .unit_en_o(dv_en), .unit_op_o(dv_op), .unit_opa_o(dv_opa), .unit_opb_o(dv_opb),
      .unit_opc_o(), .unit_tag_o(dv_tag), .unit_core_o(dv_core),
      .unit_ready_o(dv_ack)
   );

   apu_int_div u_int_div (
      .clk_i, .rst_i,
      .en_i(dv_en), .op_i(dv_op), .opa_i(dv_opa), .opb_i(dv_opb),
      .tag_i(dv_tag), .core_i(dv_core), .ack_i(dv_ack),
      .ready_o(dv_rdy), .valid_o(dv_vld), .result_o(dv_res),
      .tag_o(dv_rtag), .core_o(dv_rcore)
   );

endmodule

//--- apu_cluster_tb.sv
// Testbench for the shared arithmetic cluster
// Replays the trace on every core under random result back-pressure
// and checks results, tags, grant fairness and hold behavior

`timescale 1ns/100ps

`include "apu_cluster_cfg.svh"

module apu_cluster_tb;
   import apu_pkg::*;

   localparam int NC           = `APU_NB_CORES;
   localparam int N_ENTRIES    = 28;
   localparam int FIELDS       = 8;
   localparam int RESET_CYCLES = 16;
   localparam int IDLE_CYCLES  = 10;
   localparam int WDOG_CYCLES  = RESET_CYCLES + N_ENTRIES * 60;

   logic          clk;
   logic          rst;
   logic [NC-1:0] req;
   apu_type_e     req_type [NC];
   apu_op_e       req_op   [NC];
   word_t         opa      [NC];
   word_t         opb      [NC];
   word_t         opc      [NC];
   cpu_tag_t      req_tag  [NC];
   logic [NC-1:0] ready;
   logic [NC-1:0] ack;
   logic [NC-1:0] valid;
   word_t         result   [NC];
   cpu_tag_t      res_tag  [NC];

   // Trace words, FIELDS per request
   logic [31:0]   trace_mem [0:N_ENTRIES*FIELDS-1];
   logic          run_go;
   integer        seed;
   int            cur_entry   [NC];
   logic          issued      [N_ENTRIES];
   logic          answered    [N_ENTRIES];
   int            n_answered = 0;
   int            err_value  = 0;
   int            err_proto  = 0;
   int            passed_over [NC];
   logic          held_vld    [NC];
   word_t         held_res    [NC];
   cpu_tag_t      held_tag    [NC];

   apu_cluster u_dut (
      .clk_i(clk), .rst_i(rst),
      .req_i(req), .type_i(req_type), .op_i(req_op),
      .opa_i(opa), .opb_i(opb), .opc_i(opc), .tag_i(req_tag),
      .ready_i(ready),
      .ack_o(ack), .valid_o(valid), .result_o(result), .tag_o(res_tag)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////
   // Trace access
   //////////////////////////////

   function automatic int entry_core(input int e);
      return int'(trace_mem[FIELDS*e]);
   endfunction

   function automatic apu_type_e entry_type(input int e);
      return apu_type_e'(trace_mem[FIELDS*e+1][0]);
   endfunction

   function automatic apu_op_e entry_op(input int e);
      return apu_op_e'(trace_mem[FIELDS*e+2][2:0]);
   endfunction

   function automatic word_t entry_word(input int e, input int field);
      return trace_mem[FIELDS*e+field];
   endfunction

   function automatic cpu_tag_t entry_tag(input int e);
      return trace_mem[FIELDS*e+6][`APU_TAG_W-1:0];
   endfunction

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         err_value++;
         $display("Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_tag(input string name, input cpu_tag_t got, input cpu_tag_t exp);
      if (got !== exp) begin
         err_value++;
         $display("Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   // Match an accepted result to the outstanding request with that tag
   task automatic accept_result(input int c, input word_t res, input cpu_tag_t tag);
      int hit;
      hit = -1;
      for (int e = 0; e < N_ENTRIES; e++) begin
         if (entry_core(e) == c && entry_tag(e) == tag && issued[e] && !answered[e]) begin
            hit = e;
         end
      end
      if (hit < 0) begin
         err_proto++;
         $display("Core %0d returned tag %h, which has no outstanding request", c, tag);
      end else begin
         check_word($sformatf("result_o[%0d]", c), res, entry_word(hit, 7));
         answered[hit] = 1'b1;
         n_answered++;
      end
   endtask

   task automatic check_request_side(input int c);
      if (ack[c] && !req[c]) begin
         err_proto++;
         $display("Core %0d saw ack_o without a pending request", c);
      end
      if (ack[c]) begin
         issued[cur_entry[c]] = 1'b1;
      end
      // Round-robin fairness among cores waiting on the same unit type
      if (req[c] && !ack[c]) begin
         for (int j = 0; j < NC; j++) begin
            if (j != c && ack[j] && req_type[j] == req_type[c]) begin
               passed_over[c]++;
            end
         end
         if (passed_over[c] > 1) begin
            err_proto++;
            $display("Core %0d was passed over twice in a row while waiting", c);
            passed_over[c] = 0;
         end
      end else begin
         passed_over[c] = 0;
      end
   endtask

   task automatic check_result_side(input int c);
      // A result refused last cycle must still be on display
      if (held_vld[c]) begin
         if (!valid[c]) begin
            err_proto++;
            $display("Core %0d dropped valid_o before its result was accepted", c);
         end else begin
            check_word($sformatf("result_o[%0d]", c), result[c], held_res[c]);
            check_tag($sformatf("tag_o[%0d]", c), res_tag[c], held_tag[c]);
         end
      end
      if (valid[c] && ready[c]) begin
         accept_result(c, result[c], res_tag[c]);
      end
      held_vld[c] = valid[c] && !ready[c];
      held_res[c] = result[c];
      held_tag[c] = res_tag[c];
   endtask

   task automatic close_run(input bit timed_out);
      int missing;
      missing = 0;
      for (int e = 0; e < N_ENTRIES; e++) begin
         if (!answered[e]) begin
            missing++;
            $display("Request %0d of core %0d with tag %h was never answered",
                     e, entry_core(e), entry_tag(e));
         end
      end
      $display("Errors: value %0d, protocol %0d, unanswered %0d, timeout %0d",
               err_value, err_proto, missing, timed_out);
      if (err_value == 0 && err_proto == 0 && missing == 0 && !timed_out) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   task automatic wait_for_ack(input int c);
      do begin
         @(posedge clk);
      end while (!ack[c]);
   endtask

   for (genvar g = 0; g < NC; g++) begin : g_drv
      logic      req_q;
      apu_type_e type_q;
      apu_op_e   op_q;
      word_t     a_q, b_q, c_q;
      cpu_tag_t  tag_q;
      int        cur_e;

      assign req[g]       = req_q;
      assign req_type[g]  = type_q;
      assign req_op[g]    = op_q;
      assign opa[g]       = a_q;
      assign opb[g]       = b_q;
      assign opc[g]       = c_q;
      assign req_tag[g]   = tag_q;
      assign cur_entry[g] = cur_e;

      // Requests of this core in trace order, back to back
      initial begin
         req_q  = 1'b0;
         type_q = APU_MULT;
         op_q   = OP_MUL;
         a_q    = '0;
         b_q    = '0;
         c_q    = '0;
         tag_q  = '0;
         cur_e  = 0;
         wait (run_go);
         @(posedge clk);
         for (int e = 0; e < N_ENTRIES; e++) begin
            if (entry_core(e) == g) begin
               req_q  <= 1'b1;
               type_q <= entry_type(e);
               op_q   <= entry_op(e);
               a_q    <= entry_word(e, 3);
               b_q    <= entry_word(e, 4);
               c_q    <= entry_word(e, 5);
               tag_q  <= entry_tag(e);
               cur_e  <= e;
               wait_for_ack(g);
            end
         end
         req_q <= 1'b0;
      end
   end

   // Roughly 70 percent ready per core
   always @(posedge clk) begin
      logic [NC-1:0] rdy_next;
      for (int c = 0; c < NC; c++) begin
         rdy_next[c] = ($unsigned($random(seed)) % 100) < 70;
      end
      ready <= rdy_next;
   end

   //////////////////////////////
   // Monitor
   //////////////////////////////

   always @(posedge clk) begin
      if (rst) begin
         n_answered = 0;
         for (int e = 0; e < N_ENTRIES; e++) begin
            issued[e]   = 1'b0;
            answered[e] = 1'b0;
         end
         for (int c = 0; c < NC; c++) begin
            held_vld[c]    = 1'b0;
            passed_over[c] = 0;
         end
      end else if (!run_go) begin
         // Quiet cluster before the first request
         if (ack != '0 || valid != '0) begin
            err_proto++;
            $display("Error: ack_o = %h, valid_o = %h while idle, expected 0", ack, valid);
         end
      end else begin
         for (int c = 0; c < NC; c++) begin
            check_request_side(c);
            check_result_side(c);
         end
      end
   end

   initial begin
      rst    = 1'b1;
      run_go = 1'b0;
      ready  = '0;
      seed   = 32'h4c7460bd;
      $readmemh("apu_cluster_trace.txt", trace_mem);
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      repeat (IDLE_CYCLES) @(posedge clk);
      run_go <= 1'b1;
      wait (n_answered == N_ENTRIES);
      repeat (4) @(posedge clk);
      close_run(1'b0);
   end

   initial begin : watchdog
      repeat (WDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles", WDOG_CYCLES);
      close_run(1'b1);
   end

endmodule

//--- apu_cluster_trace.txt
// core type op opa opb opc tag expected
// type 0 mult 1 div, op 0 MUL 1 MULH 2 MAC 3 DIVU 4 REMU
0 0 0 00000003 00000007 00000000 1 00000015
1 0 0 00000010 00000020 00000000 0 00000200
0 0 0 FFFFFFFF FFFFFFFF 00000000 2 00000001
1 0 1 00010000 00010000 00000000 1 00000001
0 0 1 FFFFFFFF FFFFFFFF 00000000 3 FFFFFFFE
1 0 2 00000002 00000003 00000004 2 0000000A
0 0 2 00010000 00010000 00000005 4 00000005
1 1 3 000003E8 0000000A 00000000 3 00000064
0 1 3 00000064 00000007 00000000 5 0000000E
1 1 4 000003E9 0000000A 00000000 4 00000001
0 1 4 00000064 00000007 00000000 6 00000002
1 0 0 0000FFFF 0000FFFF 00000000 5 FFFE0001
0 1 3 12345678 00000000 00000000 7 FFFFFFFF
1 0 1 0000FFFF 0000FFFF 00000000 6 00000000
0 1 4 12345678 00000000 00000000 8 12345678
1 1 3 80000000 00000003 00000000 7 2AAAAAAA
0 0 0 12345678 00000010 00000000 9 23456780
1 1 4 80000000 00000003 00000000 8 00000002
0 0 1 80000000 00000004 00000000 A 00000002
1 0 2 00001000 00001000 FFFFFFFF 9 00FFFFFF
0 0 2 FFFFFFFF 00000002 00000003 B 00000001
1 1 3 00000000 00000000 00000000 A FFFFFFFF
0 1 3 FFFFFFFF 00000010 00000000 C 0FFFFFFF
1 1 4 00000000 00000000 00000000 B 00000000
0 1 4 FFFFFFFF 00000010 00000000 D 0000000F
1 0 1 DEADBEEF 00000100 00000000 C 000000DE
0 1 3 00000005 00000009 00000000 E 00000000
1 0 0 DEADBEEF 00000100 00000000 D ADBEEF00

//--- apu_cluster.f
+incdir+.
apu_pkg.sv
apu_core_port.sv
apu_arbiter.sv
apu_int_mult.sv
apu_int_div.sv
apu_cluster.sv
apu_cluster_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the arithmetic cluster testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
   --top-module apu_cluster_tb \
   -f apu_cluster.f \
   -Mdir obj_dir -o apu_cluster_sim

./obj_dir/apu_cluster_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi

echo "Simulation finished without failure"
